//--- hw/qpimem_bus_pkg.sv
package qpimem_bus_pkg;

	// Processor side works on 32-bit words split into byte lanes
	localparam int WORD_WIDTH = 32;
	localparam int BYTE_WIDTH = 8;
	localparam int LANES = WORD_WIDTH / BYTE_WIDTH;
	localparam int LANE_BITS = $clog2(LANES);

	// Word address into the QPI memory
	localparam int ADDR_WIDTH = 22;
	// QPI side addresses bytes
	localparam int BYTE_ADDR_WIDTH = ADDR_WIDTH + LANE_BITS;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [LANES-1:0] lane_en_t;
	typedef logic [ADDR_WIDTH-1:0] word_addr_t;
	typedef logic [BYTE_ADDR_WIDTH-1:0] byte_addr_t;

endpackage

//--- hw/qpimem_cache_pkg.sv
package qpimem_cache_pkg;

	// Geometry of the 2-way cache
	localparam int LINE_WORDS = 4;
	localparam int LINE_COUNT = 32;
	// Two lines per set, one in each way
	localparam int SETS = LINE_COUNT / 2;
	localparam int OFFSET_BITS = $clog2(LINE_WORDS);
	localparam int SET_BITS = $clog2(SETS);
	// Word address is {tag, set, offset}
	localparam int TAG_BITS = qpimem_bus_pkg::ADDR_WIDTH - SET_BITS - OFFSET_BITS;
	// Data store address is {way, set, offset}
	localparam int DATA_ADDR_BITS = 1 + SET_BITS + OFFSET_BITS;

	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [SET_BITS-1:0] set_t;
	typedef logic [OFFSET_BITS-1:0] offset_t;
	typedef logic [DATA_ADDR_BITS-1:0] data_addr_t;

	// Bit 0 is the LRU way, bit 1 dirty of way 0, bit 2 dirty of way 1
	typedef logic [2:0] flags_t;

	// Miss handling sequence of the controller
	typedef enum logic [1:0] {
		st_idle,
		st_writeback,
		st_refill,
		st_drain
	} ctrl_state_t;

endpackage

//--- hw/cache_data_if.sv
interface cache_data_if;

	// Byte-lane write enables into the data store
	qpimem_bus_pkg::lane_en_t wen;
	// {way, set, offset}
	qpimem_cache_pkg::data_addr_t addr;
	qpimem_bus_pkg::word_t wdata;
	// Registered read of the previous address
	qpimem_bus_pkg::word_t rdata;

	modport ctrl (
		output wen, addr, wdata,
		input rdata
	);

	modport mem (
		input wen, addr, wdata,
		output rdata
	);

endinterface

//--- hw/cache_meta_if.sv
interface cache_meta_if;

	// Shared set index for tags and flags
	qpimem_cache_pkg::set_t set;
	// One write enable per way
	logic [1:0] tag_wen;
	qpimem_cache_pkg::tag_t tag_wdata;
	qpimem_cache_pkg::tag_t tag_rdata0;
	qpimem_cache_pkg::tag_t tag_rdata1;
	// Flags are always written as a whole
	logic flag_wen;
	qpimem_cache_pkg::flags_t flag_wdata;
	qpimem_cache_pkg::flags_t flag_rdata;

	modport ctrl (
		output set, tag_wen, tag_wdata, flag_wen, flag_wdata,
		input tag_rdata0, tag_rdata1, flag_rdata
	);

	modport mem (
		input set, tag_wen, tag_wdata, flag_wen, flag_wdata,
		output tag_rdata0, tag_rdata1, flag_rdata
	);

endinterface

//--- hw/cache_data_mem.sv
module cache_data_mem (
	input logic clk,
	cache_data_if.mem bus
);

	// All lines of both ways, addressed as {way, set, offset}
	qpimem_bus_pkg::word_t mem [qpimem_cache_pkg::LINE_COUNT * qpimem_cache_pkg::LINE_WORDS];

	// Starts out empty, backing memory starts at zero too
	initial begin
		for (int i = 0; i < qpimem_cache_pkg::LINE_COUNT * qpimem_cache_pkg::LINE_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		// Each byte lane written on its own enable
		for (int lane = 0; lane < qpimem_bus_pkg::LANES; lane++) begin
			if (bus.wen[lane]) begin
				mem[bus.addr][lane*qpimem_bus_pkg::BYTE_WIDTH +: qpimem_bus_pkg::BYTE_WIDTH] <=
					bus.wdata[lane*qpimem_bus_pkg::BYTE_WIDTH +: qpimem_bus_pkg::BYTE_WIDTH];
			end
		end
		// Read returns the old word on a simultaneous write
		bus.rdata <= mem[bus.addr];
	end

endmodule

//--- hw/cache_meta_mem.sv
module cache_meta_mem (
	input logic clk,
	cache_meta_if.mem bus
);

	// Tag array per way, indexed by set
	qpimem_cache_pkg::tag_t tag_mem [2][qpimem_cache_pkg::SETS];
	// LRU and dirty flags for both ways of a set
	qpimem_cache_pkg::flags_t flag_mem [qpimem_cache_pkg::SETS];
	// Registered tag reads
	qpimem_cache_pkg::tag_t tag_q [2];

	// Way 0 holds tag 0 and way 1 holds tag 1 everywhere
	// LRU points at way 0, all lines clean
	initial begin
		for (int s = 0; s < qpimem_cache_pkg::SETS; s++) begin
			for (int way = 0; way < 2; way++) begin
				tag_mem[way][s] = qpimem_cache_pkg::tag_t'(way);
			end
			flag_mem[s] = '0;
		end
	end

	always_ff @(posedge clk) begin
		for (int way = 0; way < 2; way++) begin
			if (bus.tag_wen[way]) begin
				tag_mem[way][bus.set] <= bus.tag_wdata;
			end
			tag_q[way] <= tag_mem[way][bus.set];
		end
	end

	always_ff @(posedge clk) begin
		if (bus.flag_wen) begin
			flag_mem[bus.set] <= bus.flag_wdata;
		end
		bus.flag_rdata <= flag_mem[bus.set];
	end

	assign bus.tag_rdata0 = tag_q[0];
	assign bus.tag_rdata1 = tag_q[1];

endmodule

//--- hw/qpimem_cache_ctrl.sv
module qpimem_cache_ctrl (
	input logic clk,
	input logic rst,
	input qpimem_bus_pkg::word_addr_t addr,
	input qpimem_bus_pkg::lane_en_t wen,
	input logic ren,
	input qpimem_bus_pkg::word_t wdata,
	output logic ready,
	output logic qpi_do_read,
	output logic qpi_do_write,
	output qpimem_bus_pkg::byte_addr_t qpi_addr,
	output qpimem_bus_pkg::word_t qpi_wdata,
	input logic qpi_next_byte,
	input qpimem_bus_pkg::word_t qpi_rdata,
	input logic qpi_is_idle,
	cache_data_if.ctrl dmem,
	cache_meta_if.ctrl meta
);

	qpimem_cache_pkg::tag_t req_tag;
	qpimem_cache_pkg::set_t req_set;
	qpimem_cache_pkg::offset_t req_off;
	qpimem_cache_pkg::ctrl_state_t state;
	logic req;
	logic req_q;
	logic lookup;
	logic served;
	logic hit0;
	logic hit1;
	logic found_tag;
	logic hit_way;
	logic hit_now;
	logic victim;
	logic victim_dirty;
	qpimem_cache_pkg::tag_t victim_tag;
	qpimem_bus_pkg::word_addr_t wb_line;
	qpimem_bus_pkg::word_addr_t fill_line;
	qpimem_cache_pkg::offset_t xfer_off;
	qpimem_cache_pkg::offset_t qpi_word;
	logic last_word;
	logic fill_wen;
	qpimem_bus_pkg::word_t fill_data;
	logic [1:0] tag_wen_q;
	logic flag_clr;
	logic meta_busy;
	qpimem_cache_pkg::flags_t hit_flags;
	qpimem_cache_pkg::flags_t clr_flags;

	// Split the word address
	assign {req_tag, req_set, req_off} = addr;
	assign req = ren | (|wen);
	// Tag/flag reads lag the address by one edge
	assign lookup = req & req_q;

	// Both ways compared in parallel
	assign hit0 = (meta.tag_rdata0 == req_tag);
	assign hit1 = (meta.tag_rdata1 == req_tag);
	assign found_tag = hit0 | hit1;
	assign hit_way = ~hit0;
	// One hit per request, only outside miss handling
	assign hit_now = (state == qpimem_cache_pkg::st_idle) & lookup & found_tag & ~served;

	// LRU way is the one to evict
	assign victim = meta.flag_rdata[0];
	assign victim_dirty = victim ? meta.flag_rdata[2] : meta.flag_rdata[1];
	assign victim_tag = victim ? meta.tag_rdata1 : meta.tag_rdata0;

	// Line base addresses for writeback and refill
	assign wb_line = {victim_tag, req_set, qpimem_cache_pkg::offset_t'(0)};
	assign fill_line = {req_tag, req_set, qpimem_cache_pkg::offset_t'(0)};
	assign qpi_word = qpi_addr[qpimem_bus_pkg::LANE_BITS +: qpimem_cache_pkg::OFFSET_BITS];
	assign last_word = &qpi_word;

	always_comb begin
		// Hit marks the other way as LRU, a write dirties the hit way
		hit_flags = meta.flag_rdata;
		hit_flags[0] = ~hit_way;
		if (hit_way) begin
			hit_flags[2] = meta.flag_rdata[2] | (|wen);
		end else begin
			hit_flags[1] = meta.flag_rdata[1] | (|wen);
		end
		// After writeback the victim is clean again, LRU stays
		clr_flags = meta.flag_rdata;
		if (victim) begin
			clr_flags[2] = 1'b0;
		end else begin
			clr_flags[1] = 1'b0;
		end
	end

	assign meta.set = req_set;
	assign meta.tag_wdata = req_tag;
	assign meta.tag_wen = tag_wen_q;
	assign meta.flag_wen = hit_now | flag_clr;
	assign meta.flag_wdata = (state == qpimem_cache_pkg::st_idle) ? hit_flags : clr_flags;

	// Hits use the matching way, everything else the victim line
	// In idle xfer_off is zero so the first writeback word is already fetched
	assign dmem.addr = (state == qpimem_cache_pkg::st_idle && found_tag) ?
		{hit_way, req_set, req_off} : {victim, req_set, xfer_off};
	assign dmem.wen = hit_now ? wen : {qpimem_bus_pkg::LANES{fill_wen}};
	assign dmem.wdata = fill_wen ? fill_data : wdata;
	// Writeback streams straight out of the data store
	assign qpi_wdata = dmem.rdata;

	// Refill word, written to the data store one cycle after its pulse
	always_ff @(posedge clk) begin
		if (qpi_next_byte) begin
			fill_data <= qpi_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= qpimem_cache_pkg::st_idle;
			req_q <= 1'b0;
			served <= 1'b0;
			ready <= 1'b0;
			qpi_do_read <= 1'b0;
			qpi_do_write <= 1'b0;
			qpi_addr <= '0;
			xfer_off <= '0;
			fill_wen <= 1'b0;
			tag_wen_q <= '0;
			flag_clr <= 1'b0;
			meta_busy <= 1'b0;
		end else begin
			req_q <= req;
			served <= req & (served | hit_now);
			ready <= hit_now;
			fill_wen <= 1'b0;
			tag_wen_q <= '0;
			flag_clr <= 1'b0;
			// Write pending last cycle, reads not fresh yet
			meta_busy <= fill_wen | flag_clr | (|tag_wen_q);
			case (state)
				qpimem_cache_pkg::st_idle: begin
					if (lookup && !found_tag && qpi_is_idle) begin
						if (victim_dirty) begin
							qpi_do_write <= 1'b1;
							qpi_addr <= qpimem_bus_pkg::byte_addr_t'(wb_line) << qpimem_bus_pkg::LANE_BITS;
							xfer_off <= '0;
							state <= qpimem_cache_pkg::st_writeback;
						end else begin
							qpi_do_read <= 1'b1;
							qpi_addr <= qpimem_bus_pkg::byte_addr_t'(fill_line) << qpimem_bus_pkg::LANE_BITS;
							// Incremented on each pulse to the word just received
							xfer_off <= '1;
							state <= qpimem_cache_pkg::st_refill;
						end
					end
				end
				qpimem_cache_pkg::st_writeback: begin
					if (qpi_next_byte) begin
						qpi_addr[qpimem_bus_pkg::LANE_BITS +: qpimem_cache_pkg::OFFSET_BITS] <=
							qpi_word + 1'b1;
						xfer_off <= xfer_off + 1'b1;
						if (last_word) begin
							qpi_do_write <= 1'b0;
							flag_clr <= 1'b1;
							state <= qpimem_cache_pkg::st_drain;
						end
					end
				end
				qpimem_cache_pkg::st_refill: begin
					if (qpi_next_byte) begin
						qpi_addr[qpimem_bus_pkg::LANE_BITS +: qpimem_cache_pkg::OFFSET_BITS] <=
							qpi_word + 1'b1;
						xfer_off <= xfer_off + 1'b1;
						fill_wen <= 1'b1;
						if (last_word) begin
							qpi_do_read <= 1'b0;
							// New tag goes into the refilled way
							tag_wen_q <= victim ? 2'b10 : 2'b01;
							state <= qpimem_cache_pkg::st_drain;
						end
					end
				end
				qpimem_cache_pkg::st_drain: begin
					// Wait for the QPI side and for fresh tag/flag reads
					if (qpi_is_idle && !meta_busy && !fill_wen && !flag_clr && tag_wen_q == '0) begin
						xfer_off <= '0;
						state <= qpimem_cache_pkg::st_idle;
					end
				end
				default: begin
					state <= qpimem_cache_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

//--- hw/qpimem_cache_top.sv
module qpimem_cache_top (
	input logic clk,
	input logic rst,

	// Processor request side
	input qpimem_bus_pkg::word_addr_t addr,
	input qpimem_bus_pkg::lane_en_t wen,
	input logic ren,
	input qpimem_bus_pkg::word_t wdata,
	output qpimem_bus_pkg::word_t rdata,
	output logic ready,

	// QPI word-level side
	output logic qpi_do_read,
	output logic qpi_do_write,
	output qpimem_bus_pkg::byte_addr_t qpi_addr,
	output qpimem_bus_pkg::word_t qpi_wdata,
	input logic qpi_next_byte,
	input qpimem_bus_pkg::word_t qpi_rdata,
	input logic qpi_is_idle
);

	cache_data_if dif ();
	cache_meta_if mif ();

	qpimem_cache_ctrl i_ctrl (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.wen(wen),
		.ren(ren),
		.wdata(wdata),
		.ready(ready),
		.qpi_do_read(qpi_do_read),
		.qpi_do_write(qpi_do_write),
		.qpi_addr(qpi_addr),
		.qpi_wdata(qpi_wdata),
		.qpi_next_byte(qpi_next_byte),
		.qpi_rdata(qpi_rdata),
		.qpi_is_idle(qpi_is_idle),
		.dmem(dif.ctrl),
		.meta(mif.ctrl)
	);

	cache_data_mem i_data_mem (
		.clk(clk),
		.bus(dif.mem)
	);

	cache_meta_mem i_meta_mem (
		.clk(clk),
		.bus(mif.mem)
	);

	// Read data comes straight from the data store, valid with ready
	assign rdata = dif.rdata;

endmodule

//--- tests/qpimem_model.sv
module qpimem_model (
	input logic clk,
	input logic do_read,
	input logic do_write,
	input qpimem_bus_pkg::byte_addr_t addr,
	input qpimem_bus_pkg::word_t wdata,
	output logic next_byte,
	output qpimem_bus_pkg::word_t rdata,
	output logic is_idle
);

	// Sparse backing store, words never written read as zero
	qpimem_bus_pkg::word_t mem [qpimem_bus_pkg::word_addr_t];
	// Transaction counters, read by the testbench
	int read_count;
	int write_count;
	// Line address of the most recent write transaction
	qpimem_bus_pkg::byte_addr_t last_write_addr;
	logic active;
	int gap;
	int idle_hold;

	function automatic qpimem_bus_pkg::word_t read_word(input qpimem_bus_pkg::word_addr_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return '0;
	endfunction

	initial begin
		next_byte = 1'b0;
		rdata = '0;
		is_idle = 1'b1;
		active = 1'b0;
		gap = 0;
		idle_hold = 0;
		read_count = 0;
		write_count = 0;
		last_write_addr = '0;
		forever begin
			@(posedge clk);
			#1;
			next_byte = 1'b0;
			if (do_read || do_write) begin
				// New transaction starts on the rising strobe
				if (!active) begin
					active = 1'b1;
					is_idle = 1'b0;
					gap = 0;
					if (do_write) begin
						write_count++;
						last_write_addr = addr;
					end else begin
						read_count++;
					end
				end
				gap++;
				// One word every third cycle
				if (gap == 3) begin
					gap = 0;
					next_byte = 1'b1;
					if (do_write) begin
						mem[addr[qpimem_bus_pkg::BYTE_ADDR_WIDTH-1:qpimem_bus_pkg::LANE_BITS]] = wdata;
					end else begin
						rdata = read_word(addr[qpimem_bus_pkg::BYTE_ADDR_WIDTH-1:qpimem_bus_pkg::LANE_BITS]);
					end
				end
			end else if (active) begin
				// Bus stays busy a little after the strobe drops
				active = 1'b0;
				idle_hold = 2;
			end else if (idle_hold > 0) begin
				idle_hold--;
				if (idle_hold == 0) begin
					is_idle = 1'b1;
				end
			end
		end
	end

endmodule

//--- tests/qpimem_cache_checker.sv
module qpimem_cache_checker (
	input logic clk,
	input logic rst,
	input logic ready,
	input logic qpi_do_read,
	input logic qpi_do_write,
	input qpimem_bus_pkg::byte_addr_t qpi_addr
);

	// Assertion failures so far, read by the testbench at the end
	int fail_count;

	initial begin
		fail_count = 0;
	end

	// Only one transfer direction at a time
	strobe_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(qpi_do_read && qpi_do_write))
	else begin
		$error("qpi_do_read and qpi_do_write high together");
		fail_count++;
	end

	// Requests are never answered during a QPI transfer
	ready_quiet: assert property (@(posedge clk) disable iff (rst)
		ready |-> !(qpi_do_read || qpi_do_write))
	else begin
		$error("ready high while a QPI strobe is high");
		fail_count++;
	end

	// Transfers always start at the first word of a line
	line_aligned: assert property (@(posedge clk) disable iff (rst)
		($rose(qpi_do_read) || $rose(qpi_do_write)) |->
		qpi_addr[qpimem_bus_pkg::LANE_BITS+qpimem_cache_pkg::OFFSET_BITS-1:0] == '0)
	else begin
		$error("qpi_addr not line aligned at transfer start");
		fail_count++;
	end

endmodule

bind qpimem_cache_top qpimem_cache_checker i_checker (
	.clk(clk),
	.rst(rst),
	.ready(ready),
	.qpi_do_read(qpi_do_read),
	.qpi_do_write(qpi_do_write),
	.qpi_addr(qpi_addr)
);

//--- tests/qpimem_cache_tb.sv
module qpimem_cache_tb;

	localparam int REQ_TIMEOUT = 400;

	logic clk;
	logic rst;
	qpimem_bus_pkg::word_addr_t addr;
	qpimem_bus_pkg::lane_en_t wen;
	logic ren;
	qpimem_bus_pkg::word_t wdata;
	qpimem_bus_pkg::word_t rdata;
	logic ready;
	logic qpi_do_read;
	logic qpi_do_write;
	qpimem_bus_pkg::byte_addr_t qpi_addr;
	qpimem_bus_pkg::word_t qpi_wdata;
	logic qpi_next_byte;
	qpimem_bus_pkg::word_t qpi_rdata;
	logic qpi_is_idle;

	int checks;
	int errors;
	int timeouts;
	int reads_mark;
	int writes_mark;
	logic [31:0] rng_state;
	// Expected memory contents as seen by the processor
	qpimem_bus_pkg::word_t shadow [qpimem_bus_pkg::word_addr_t];

	qpimem_cache_top i_dut (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.wen(wen),
		.ren(ren),
		.wdata(wdata),
		.rdata(rdata),
		.ready(ready),
		.qpi_do_read(qpi_do_read),
		.qpi_do_write(qpi_do_write),
		.qpi_addr(qpi_addr),
		.qpi_wdata(qpi_wdata),
		.qpi_next_byte(qpi_next_byte),
		.qpi_rdata(qpi_rdata),
		.qpi_is_idle(qpi_is_idle)
	);

	qpimem_model i_model (
		.clk(clk),
		.do_read(qpi_do_read),
		.do_write(qpi_do_write),
		.addr(qpi_addr),
		.wdata(qpi_wdata),
		.next_byte(qpi_next_byte),
		.rdata(qpi_rdata),
		.is_idle(qpi_is_idle)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic qpimem_bus_pkg::word_addr_t make_addr(input qpimem_cache_pkg::tag_t t,
		input qpimem_cache_pkg::set_t s, input qpimem_cache_pkg::offset_t o);
		return {t, s, o};
	endfunction

	// Odd multiplier keeps every word of the pattern distinct
	function automatic qpimem_bus_pkg::word_t pattern(input qpimem_bus_pkg::word_addr_t a);
		return qpimem_bus_pkg::word_t'(a) * 32'h9E37_79B1 + 32'h1357_9BDF;
	endfunction

	function automatic qpimem_bus_pkg::word_t shadow_word(input qpimem_bus_pkg::word_addr_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return '0;
	endfunction

	// Byte lanes with their enable set take the new data
	function automatic qpimem_bus_pkg::word_t merge_lanes(input qpimem_bus_pkg::word_t old_word,
		input qpimem_bus_pkg::word_t new_word, input qpimem_bus_pkg::lane_en_t lanes);
		qpimem_bus_pkg::word_t merged;
		merged = old_word;
		for (int i = 0; i < qpimem_bus_pkg::LANES; i++) begin
			if (lanes[i]) begin
				merged[i*8 +: 8] = new_word[i*8 +: 8];
			end
		end
		return merged;
	endfunction

	task automatic check_word(input string name, input qpimem_bus_pkg::word_t got,
		input qpimem_bus_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input integer got, input integer exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input qpimem_bus_pkg::byte_addr_t got,
		input qpimem_bus_pkg::byte_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Request held until ready and followed by one idle cycle
	task automatic do_request(input qpimem_bus_pkg::word_addr_t a, input qpimem_bus_pkg::lane_en_t we,
		input logic re, input qpimem_bus_pkg::word_t wd, output qpimem_bus_pkg::word_t rd);
		int cycles;
		cycles = 0;
		rd = '0;
		addr = a;
		wen = we;
		ren = re;
		wdata = wd;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!ready && cycles < REQ_TIMEOUT);
		if (ready) begin
			rd = rdata;
		end else begin
			timeouts++;
			$display("Request at word address %h got no ready within %0d cycles", a, cycles);
		end
		wen = '0;
		ren = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic read_and_check(input qpimem_bus_pkg::word_addr_t a);
		qpimem_bus_pkg::word_t rd;
		do_request(a, '0, 1'b1, '0, rd);
		check_word($sformatf("rdata at %h", a), rd, shadow_word(a));
	endtask

	task automatic write_word_at(input qpimem_bus_pkg::word_addr_t a,
		input qpimem_bus_pkg::lane_en_t lanes, input qpimem_bus_pkg::word_t wd);
		qpimem_bus_pkg::word_t rd;
		do_request(a, lanes, 1'b0, wd, rd);
		shadow[a] = merge_lanes(shadow_word(a), wd, lanes);
	endtask

	// Same pattern into the model and the shadow copy
	task automatic preload_line(input qpimem_cache_pkg::tag_t t, input qpimem_cache_pkg::set_t s);
		qpimem_bus_pkg::word_addr_t a;
		for (int o = 0; o < qpimem_cache_pkg::LINE_WORDS; o++) begin
			a = make_addr(t, s, qpimem_cache_pkg::offset_t'(o));
			i_model.mem[a] = pattern(a);
			shadow[a] = pattern(a);
		end
	endtask

	task automatic mark_counts();
		reads_mark = i_model.read_count;
		writes_mark = i_model.write_count;
	endtask

	task automatic check_traffic(input integer exp_reads, input integer exp_writes);
		check_count("read transactions", i_model.read_count - reads_mark, exp_reads);
		check_count("write transactions", i_model.write_count - writes_mark, exp_writes);
	endtask

	task automatic test_cold_read();
		preload_line(16'h0005, 4'd3);
		mark_counts();
		read_and_check(make_addr(16'h0005, 4'd3, 2'd1));
		check_traffic(1, 0);
	endtask

	task automatic test_same_line();
		mark_counts();
		read_and_check(make_addr(16'h0005, 4'd3, 2'd0));
		read_and_check(make_addr(16'h0005, 4'd3, 2'd2));
		read_and_check(make_addr(16'h0005, 4'd3, 2'd3));
		check_traffic(0, 0);
	endtask

	task automatic test_partial_write();
		mark_counts();
		write_word_at(make_addr(16'h0005, 4'd3, 2'd2), 4'b0101, 32'hAABB_CCDD);
		read_and_check(make_addr(16'h0005, 4'd3, 2'd2));
		check_traffic(0, 0);
	endtask

	// A, B, A, C in set 7 leaves B as the line that went out
	task automatic test_lru();
		preload_line(16'h0020, 4'd7);
		preload_line(16'h0021, 4'd7);
		preload_line(16'h0022, 4'd7);
		read_and_check(make_addr(16'h0020, 4'd7, 2'd0));
		read_and_check(make_addr(16'h0021, 4'd7, 2'd0));
		read_and_check(make_addr(16'h0020, 4'd7, 2'd0));
		read_and_check(make_addr(16'h0022, 4'd7, 2'd0));
		mark_counts();
		read_and_check(make_addr(16'h0020, 4'd7, 2'd1));
		check_traffic(0, 0);
		read_and_check(make_addr(16'h0021, 4'd7, 2'd1));
		check_traffic(1, 0);
	endtask

	task automatic test_dirty_evict();
		qpimem_bus_pkg::word_addr_t a;
		preload_line(16'h0030, 4'd9);
		preload_line(16'h0031, 4'd9);
		preload_line(16'h0032, 4'd9);
		mark_counts();
		write_word_at(make_addr(16'h0030, 4'd9, 2'd0), 4'b0011, 32'h1234_5678);
		write_word_at(make_addr(16'h0030, 4'd9, 2'd3), 4'b1100, 32'hCAFE_F00D);
		read_and_check(make_addr(16'h0031, 4'd9, 2'd0));
		read_and_check(make_addr(16'h0032, 4'd9, 2'd0));
		check_traffic(3, 1);
		check_addr("writeback qpi_addr", i_model.last_write_addr,
			{make_addr(16'h0030, 4'd9, 2'd0), 2'b00});
		// Backing memory now holds the merged line
		for (int o = 0; o < qpimem_cache_pkg::LINE_WORDS; o++) begin
			a = make_addr(16'h0030, 4'd9, qpimem_cache_pkg::offset_t'(o));
			check_word($sformatf("model word at %h", a), i_model.read_word(a), shadow_word(a));
		end
	endtask

	// Random accesses over sets 12 to 15 and tags 0x40 to 0x47
	task automatic test_random();
		logic [31:0] r;
		qpimem_bus_pkg::word_addr_t a;
		for (int i = 0; i < 64; i++) begin
			rng_state = xorshift32(rng_state);
			r = rng_state;
			a = make_addr({13'h0008, r[4:2]}, {2'b11, r[1:0]}, r[6:5]);
			if (r[7] && r[11:8] != 4'b0000) begin
				rng_state = xorshift32(rng_state);
				write_word_at(a, r[11:8], rng_state);
			end else begin
				read_and_check(a);
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		addr = '0;
		wen = '0;
		ren = 1'b0;
		wdata = '0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		reads_mark = 0;
		writes_mark = 0;
		rng_state = 32'd78516;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		test_cold_read();
		test_same_line();
		test_partial_write();
		test_lru();
		test_dirty_evict();
		test_random();
		$display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
			checks, errors, timeouts, i_dut.i_checker.fail_count);
		if (errors == 0 && timeouts == 0 && i_dut.i_checker.fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- qpimem_cache_top.f
hw/qpimem_bus_pkg.sv
hw/qpimem_cache_pkg.sv
hw/cache_data_if.sv
hw/cache_meta_if.sv
hw/cache_data_mem.sv
hw/cache_meta_mem.sv
hw/qpimem_cache_ctrl.sv
hw/qpimem_cache_top.sv
tests/qpimem_model.sv
tests/qpimem_cache_checker.sv
tests/qpimem_cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module qpimem_cache_tb -Mdir obj_dir -f qpimem_cache_top.f

status=0
./obj_dir/Vqpimem_cache_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
